//--- gprAddrGen.f
+incdir+design
design/gprAddrPkg.sv
design/gprAddrCtrl.sv
design/targetPipe.sv
design/bypassCmp.sv
design/gprAddrGen.sv
testbench/gprAddrGen_assertions.sv
testbench/gprAddrGen_tb.sv

//--- Makefile
# Verilator build for the GPR address generator testbench
SIM      = verilator
TOP      = gprAddrGen_tb
FILELIST = gprAddrGen.f
BUILDDIR = obj_dir
FLAGS    = --binary --timing --assert -j 0 --Mdir $(BUILDDIR) --top-module $(TOP)

SOURCES  = $(wildcard design/*.sv design/*.svh testbench/*.sv)
BINARY   = $(BUILDDIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BINARY)

$(BINARY): $(FILELIST) $(SOURCES)
	$(SIM) $(FLAGS) -f $(FILELIST)

# Exit status of the simulator is the pass/fail result
run: $(BINARY)
	./$(BINARY)

clean:
	rm -rf $(BUILDDIR)

//--- testbench/gprAddrGen_tb.sv
// Self-checking testbench for the GPR address generator
// Decode rows are held until dcdAccept_o
// hold_i comes from $random with a fixed seed
// Expected values come from a stage model kept inside the testbench
`default_nettype none

`include "gprAddr_config.svh"

module gprAddrGen_tb;

  localparam int NUM_ROWS   = 12;
  localparam int MAX_CYCLES = NUM_ROWS * 32 * 2 + 50;

  typedef struct packed {
    gprAddrPkg::priOp_t   priOp;
    gprAddrPkg::extOp_t   extOp;
    gprAddrPkg::gprAddr_t ra;
    gprAddrPkg::gprAddr_t rb;
    gprAddrPkg::gprAddr_t rsRt;
  } stimRow_t;

  logic CB, rstN, dcdValid, hold, dcdAccept, wbRpValid, lwbLpValid;
  gprAddrPkg::priOp_t   priOp;
  gprAddrPkg::extOp_t   extOp;
  gprAddrPkg::gprAddr_t ra, rb, rsRt, aAddr, bAddr, sAddr, wbRpAddr, lwbLpAddr;
  gprAddrPkg::bypSrc_t  aByp, bByp, sByp;

  stimRow_t rows [NUM_ROWS];
  integer   seed;
  int       rowIdx, cycleCount;

  // Stage model and sequencer model
  gprAddrPkg::gprAddr_t mExeRp, mExeLp, mWbRp, mWbLp, mLwbLp, mIdx;
  logic mExeRpV, mExeLpV, mWbRpV, mWbLpV, mLwbLpV, mMulti;
  gprAddrPkg::gprAddr_t rpQueue[$];
  gprAddrPkg::gprAddr_t lpQueue[$];

  // Outputs seen in the previous cycle
  logic prevHold, prevWbRpV, prevLwbLpV;
  gprAddrPkg::gprAddr_t prevWbRp, prevLwbLp;
  gprAddrPkg::bypSrc_t  prevAByp, prevBByp, prevSByp;

  gprAddrGen uut
  (
    .CB (CB), .rstN_i (rstN), .dcdValid_i (dcdValid), .hold_i (hold),
    .priOp_i (priOp), .extOp_i (extOp), .ra_i (ra), .rb_i (rb), .rsRt_i (rsRt),
    .dcdAccept_o (dcdAccept), .aAddr_o (aAddr), .bAddr_o (bAddr), .sAddr_o (sAddr),
    .aByp_o (aByp), .bByp_o (bByp), .sByp_o (sByp),
    .wbRpValid_o (wbRpValid), .wbRpAddr_o (wbRpAddr),
    .lwbLpValid_o (lwbLpValid), .lwbLpAddr_o (lwbLpAddr)
  );

  initial
  begin
    CB = 1'b0;
    forever #50 CB = ~CB;
  end

  task checkValue(input logic [31:0] actual, input logic [31:0] expected, input string what);
    if (actual !== expected)
    begin
      $display("Mismatch at time %0t: %s (got %0d, expected %0d)", $time, what, actual, expected);
      $display("TB FAILED");
      $fatal(1, "Stopped at first mismatch");
    end
  endtask

  function automatic gprAddrPkg::opKind_t expectKind(input gprAddrPkg::priOp_t p,
                                                     input gprAddrPkg::extOp_t x);
    if (p == `OP_ADDI || (p == `OP_EXT && x == `XO_ADD))
      return gprAddrPkg::OP_RESULT;
    if (p == `OP_LWZ || (p == `OP_EXT && x == `XO_LWZX))
      return gprAddrPkg::OP_LOAD;
    if (p == `OP_STW || (p == `OP_EXT && x == `XO_STWX))
      return gprAddrPkg::OP_STORE;
    if (p == `OP_LMW)
      return gprAddrPkg::OP_LOADMULTI;
    if (p == `OP_STMW)
      return gprAddrPkg::OP_STOREMULTI;
    return gprAddrPkg::OP_NONE;
  endfunction

  // Youngest stage first
  // A load still in exe forces a wait
  function automatic gprAddrPkg::bypSrc_t expectByp(input gprAddrPkg::gprAddr_t addr);
    if (mExeLpV && mExeLp == addr)
      return gprAddrPkg::BYP_WAIT;
    if (mExeRpV && mExeRp == addr)
      return gprAddrPkg::BYP_EXE;
    if ((mWbRpV && mWbRp == addr) || (mWbLpV && mWbLp == addr))
      return gprAddrPkg::BYP_WB;
    if (mLwbLpV && mLwbLp == addr)
      return gprAddrPkg::BYP_LWB;
    return gprAddrPkg::BYP_NONE;
  endfunction

  // ******************************************************************
  // One clock cycle of drive, check and model update
  // ******************************************************************
  task runCycle;
    gprAddrPkg::opKind_t  kind;
    gprAddrPkg::gprAddr_t curIdx;
    gprAddrPkg::gprAddr_t expS;
    logic                 isMulti, expIssue, expAccept;
    @(negedge CB);
    hold = (($random(seed) & 3) == 0);
    dcdValid = (rowIdx < NUM_ROWS);
    if (rowIdx < NUM_ROWS)
    begin
      priOp = rows[rowIdx].priOp;
      extOp = rows[rowIdx].extOp;
      ra    = rows[rowIdx].ra;
      rb    = rows[rowIdx].rb;
      rsRt  = rows[rowIdx].rsRt;
    end
    #10;
    kind      = expectKind(priOp, extOp);
    isMulti   = (kind == gprAddrPkg::OP_LOADMULTI) || (kind == gprAddrPkg::OP_STOREMULTI);
    curIdx    = mMulti ? mIdx : rsRt;
    expS      = (kind == gprAddrPkg::OP_STOREMULTI) ? curIdx : rsRt;
    expIssue  = dcdValid && !hold;
    expAccept = expIssue && (!isMulti || curIdx == gprAddrPkg::gprAddr_t'(`LAST_GPR));
    checkValue(32'(dcdAccept), 32'(expAccept), "dcdAccept_o");
    checkValue(32'(aAddr), 32'(ra), "aAddr_o");
    checkValue(32'(bAddr), 32'(rb), "bAddr_o");
    checkValue(32'(sAddr), 32'(expS), "sAddr_o");
    checkValue(32'(wbRpValid), 32'(mWbRpV), "wbRpValid_o");
    checkValue(32'(lwbLpValid), 32'(mLwbLpV), "lwbLpValid_o");
    if (mWbRpV)
      checkValue(32'(wbRpAddr), 32'(mWbRp), "wbRpAddr_o");
    if (mLwbLpV)
      checkValue(32'(lwbLpAddr), 32'(mLwbLp), "lwbLpAddr_o");
    checkValue(32'(aByp), 32'(expectByp(ra)), "aByp_o");
    checkValue(32'(bByp), 32'(expectByp(rb)), "bByp_o");
    checkValue(32'(sByp), 32'(expectByp(expS)), "sByp_o");
    // A held edge leaves every output where it was
    if (prevHold)
    begin
      checkValue(32'(wbRpValid), 32'(prevWbRpV), "wbRpValid_o after hold");
      checkValue(32'(wbRpAddr), 32'(prevWbRp), "wbRpAddr_o after hold");
      checkValue(32'(lwbLpValid), 32'(prevLwbLpV), "lwbLpValid_o after hold");
      checkValue(32'(lwbLpAddr), 32'(prevLwbLp), "lwbLpAddr_o after hold");
      checkValue(32'(aByp), 32'(prevAByp), "aByp_o after hold");
      checkValue(32'(bByp), 32'(prevBByp), "bByp_o after hold");
      checkValue(32'(sByp), 32'(prevSByp), "sByp_o after hold");
    end
    // Register file writes in issue order
    if (!hold && wbRpValid)
    begin
      checkValue(32'(rpQueue.size() != 0), 32'd1, "Rp write with no result issued");
      checkValue(32'(wbRpAddr), 32'(rpQueue.pop_front()), "Rp write order");
    end
    if (!hold && lwbLpValid)
    begin
      checkValue(32'(lpQueue.size() != 0), 32'd1, "Lp write with no load issued");
      checkValue(32'(lwbLpAddr), 32'(lpQueue.pop_front()), "Lp write order");
    end
    if (expIssue)
    begin
      if (kind == gprAddrPkg::OP_RESULT)
        rpQueue.push_back(rsRt);
      if (kind == gprAddrPkg::OP_LOAD)
        lpQueue.push_back(rsRt);
      if (kind == gprAddrPkg::OP_LOADMULTI)
        lpQueue.push_back(curIdx);
    end
    prevHold   = hold;
    prevWbRpV  = wbRpValid;
    prevWbRp   = wbRpAddr;
    prevLwbLpV = lwbLpValid;
    prevLwbLp  = lwbLpAddr;
    prevAByp   = aByp;
    prevBByp   = bByp;
    prevSByp   = sByp;
    @(posedge CB);
    if (!hold)
    begin
      mLwbLp  = mWbLp;
      mLwbLpV = mWbLpV;
      mWbRp   = mExeRp;
      mWbRpV  = mExeRpV;
      mWbLp   = mExeLp;
      mWbLpV  = mExeLpV;
      mExeRp  = rsRt;
      mExeRpV = expIssue && (kind == gprAddrPkg::OP_RESULT);
      mExeLp  = (kind == gprAddrPkg::OP_LOADMULTI) ? curIdx : rsRt;
      mExeLpV = expIssue && (kind == gprAddrPkg::OP_LOAD || kind == gprAddrPkg::OP_LOADMULTI);
    end
    if (expIssue && isMulti)
    begin
      mMulti = !expAccept;
      mIdx   = curIdx + 5'd1;
    end
    if (expAccept)
      rowIdx++;
  endtask

  // ******************************************************************
  // Stimulus table and main sequence
  // ******************************************************************
  initial
  begin
    // priOp, extOp, RA, RB, rsRt
    rows[0]  = '{`OP_ADDI, 10'd0, 5'd1, 5'd0, 5'd5};
    rows[1]  = '{`OP_EXT, `XO_ADD, 5'd5, 5'd5, 5'd6};
    rows[2]  = '{`OP_LWZ, 10'd0, 5'd6, 5'd2, 5'd7};
    rows[3]  = '{`OP_EXT, `XO_LWZX, 5'd7, 5'd6, 5'd8};
    rows[4]  = '{`OP_STW, 10'd0, 5'd7, 5'd3, 5'd8};
    rows[5]  = '{`OP_EXT, `XO_STWX, 5'd8, 5'd5, 5'd7};
    rows[6]  = '{`OP_LMW, 10'd0, 5'd8, 5'd0, 5'd28};
    rows[7]  = '{`OP_STMW, 10'd0, 5'd30, 5'd28, 5'd29};
    rows[8]  = '{6'd0, 10'd0, 5'd31, 5'd29, 5'd4};
    rows[9]  = '{`OP_EXT, `XO_ADD, 5'd30, 5'd29, 5'd31};
    rows[10] = '{`OP_ADDI, 10'd0, 5'd31, 5'd0, 5'd9};
    rows[11] = '{`OP_STW, 10'd0, 5'd31, 5'd9, 5'd9};
    seed = 49;
    {rstN, dcdValid, hold, priOp, extOp, ra, rb, rsRt} = '0;
    {mExeRpV, mExeLpV, mWbRpV, mWbLpV, mLwbLpV, mMulti, prevHold} = '0;
    {mExeRp, mExeLp, mWbRp, mWbLp, mLwbLp, mIdx} = '0;
    rowIdx    = NUM_ROWS;
    repeat (8) @(negedge CB);
    rstN = 1'b1;
    #10;
    checkValue(32'(wbRpValid), 32'd0, "wbRpValid_o after reset");
    checkValue(32'(lwbLpValid), 32'd0, "lwbLpValid_o after reset");
    checkValue(32'(aByp), 32'(gprAddrPkg::BYP_NONE), "aByp_o after reset");
    checkValue(32'(bByp), 32'(gprAddrPkg::BYP_NONE), "bByp_o after reset");
    checkValue(32'(sByp), 32'(gprAddrPkg::BYP_NONE), "sByp_o after reset");
    repeat (2) runCycle();
    rowIdx = 0;
    while (rowIdx < NUM_ROWS)
      runCycle();
    // Drain the pipe until every write has been seen
    while (rpQueue.size() != 0 || lpQueue.size() != 0)
      runCycle();
    repeat (4) runCycle();
    $display("TB PASSED");
    $finish;
  end

  initial
  begin
    cycleCount = 0;
    while (cycleCount < MAX_CYCLES)
    begin
      @(posedge CB);
      cycleCount++;
    end
    $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
    $display("TB FAILED");
    $fatal(1, "Simulation timed out");
  end

endmodule

`default_nettype wire

//--- testbench/gprAddrGen_assertions.sv
// Protocol checks bound onto the GPR address generator top level
// Reset check starts at the second clock edge inside reset
`default_nettype none

module gprAddrGen_assertions
(
  input wire CB,
  input wire rstN_i,
  input wire dcdValid_i,
  input wire hold_i,
  input wire dcdAccept_i,
  input wire wbRpValid_i,
  input wire lwbLpValid_i
);

  // Accept only in an issuing cycle
  acceptNeedsIssue: assert property (
    @(posedge CB) disable iff (!rstN_i)
    dcdAccept_i |-> (dcdValid_i && !hold_i)
  ) else $error("dcdAccept_o high while held or without a valid decode");

  validsLowInReset: assert property (
    @(posedge CB)
    (!rstN_i && $past(!rstN_i)) |-> (!wbRpValid_i && !lwbLpValid_i)
  ) else $error("Stage valid high during reset");

  validsKnown: assert property (
    @(posedge CB) disable iff (!rstN_i)
    !$isunknown({wbRpValid_i, lwbLpValid_i})
  ) else $error("Stage valid is unknown");

endmodule

bind gprAddrGen gprAddrGen_assertions protocolChk
(
  .CB           (CB),
  .rstN_i       (rstN_i),
  .dcdValid_i   (dcdValid_i),
  .hold_i       (hold_i),
  .dcdAccept_i  (dcdAccept_o),
  .wbRpValid_i  (wbRpValid_o),
  .lwbLpValid_i (lwbLpValid_o)
);

`default_nettype wire

//--- design/gprAddrGen.sv
// GPR address generator top level
// hold_i stalls the whole pipe, there is no other back-pressure
// Bypass outputs are combinational from the decode fields
`default_nettype none

module gprAddrGen
(
  input  wire                     CB,
  input  wire                     rstN_i,
  input  wire                     dcdValid_i,
  input  wire                     hold_i,
  input  gprAddrPkg::priOp_t      priOp_i,
  input  gprAddrPkg::extOp_t      extOp_i,
  input  gprAddrPkg::gprAddr_t    ra_i,
  input  gprAddrPkg::gprAddr_t    rb_i,
  input  gprAddrPkg::gprAddr_t    rsRt_i,
  output logic                    dcdAccept_o,
  output gprAddrPkg::gprAddr_t    aAddr_o,
  output gprAddrPkg::gprAddr_t    bAddr_o,
  output gprAddrPkg::gprAddr_t    sAddr_o,
  output gprAddrPkg::bypSrc_t     aByp_o,
  output gprAddrPkg::bypSrc_t     bByp_o,
  output gprAddrPkg::bypSrc_t     sByp_o,
  output logic                    wbRpValid_o,
  output gprAddrPkg::gprAddr_t    wbRpAddr_o,
  output logic                    lwbLpValid_o,
  output gprAddrPkg::gprAddr_t    lwbLpAddr_o
);

  logic                 issue;
  gprAddrPkg::gprAddr_t issueRp;
  logic                 issueRpValid;
  gprAddrPkg::gprAddr_t issueLp;
  logic                 issueLpValid;

  gprAddrPkg::gprAddr_t exeRp;
  logic                 exeRpValid;
  gprAddrPkg::gprAddr_t exeLp;
  logic                 exeLpValid;
  gprAddrPkg::gprAddr_t wbLp;
  logic                 wbLpValid;

  // *******************************************************************
  // Decode and sequencing
  // *******************************************************************
  gprAddrCtrl ctrl
  (
    .CB             (CB),
    .rstN_i         (rstN_i),
    .dcdValid_i     (dcdValid_i),
    .hold_i         (hold_i),
    .priOp_i        (priOp_i),
    .extOp_i        (extOp_i),
    .ra_i           (ra_i),
    .rb_i           (rb_i),
    .rsRt_i         (rsRt_i),
    .dcdAccept_o    (dcdAccept_o),
    .aAddr_o        (aAddr_o),
    .bAddr_o        (bAddr_o),
    .sAddr_o        (sAddr_o),
    .issue_o        (issue),
    .issueRp_o      (issueRp),
    .issueRpValid_o (issueRpValid),
    .issueLp_o      (issueLp),
    .issueLpValid_o (issueLpValid)
  );

  targetPipe pipe
  (
    .CB             (CB),
    .rstN_i         (rstN_i),
    .hold_i         (hold_i),
    .issue_i        (issue),
    .issueRp_i      (issueRp),
    .issueRpValid_i (issueRpValid),
    .issueLp_i      (issueLp),
    .issueLpValid_i (issueLpValid),
    .exeRp_o        (exeRp),
    .exeRpValid_o   (exeRpValid),
    .exeLp_o        (exeLp),
    .exeLpValid_o   (exeLpValid),
    .wbRp_o         (wbRpAddr_o),
    .wbRpValid_o    (wbRpValid_o),
    .wbLp_o         (wbLp),
    .wbLpValid_o    (wbLpValid),
    .lwbLp_o        (lwbLpAddr_o),
    .lwbLpValid_o   (lwbLpValid_o)
  );

  // *******************************************************************
  // One classifier per read port
  // *******************************************************************
  bypassCmp aCmp
  (
    .portAddr_i (aAddr_o),
    .exeRp_i    (exeRp),       .exeRpValid_i (exeRpValid),
    .exeLp_i    (exeLp),       .exeLpValid_i (exeLpValid),
    .wbRp_i     (wbRpAddr_o),  .wbRpValid_i  (wbRpValid_o),
    .wbLp_i     (wbLp),        .wbLpValid_i  (wbLpValid),
    .lwbLp_i    (lwbLpAddr_o), .lwbLpValid_i (lwbLpValid_o),
    .byp_o      (aByp_o)
  );

  bypassCmp bCmp
  (
    .portAddr_i (bAddr_o),
    .exeRp_i    (exeRp),       .exeRpValid_i (exeRpValid),
    .exeLp_i    (exeLp),       .exeLpValid_i (exeLpValid),
    .wbRp_i     (wbRpAddr_o),  .wbRpValid_i  (wbRpValid_o),
    .wbLp_i     (wbLp),        .wbLpValid_i  (wbLpValid),
    .lwbLp_i    (lwbLpAddr_o), .lwbLpValid_i (lwbLpValid_o),
    .byp_o      (bByp_o)
  );

  bypassCmp sCmp
  (
    .portAddr_i (sAddr_o),
    .exeRp_i    (exeRp),       .exeRpValid_i (exeRpValid),
    .exeLp_i    (exeLp),       .exeLpValid_i (exeLpValid),
    .wbRp_i     (wbRpAddr_o),  .wbRpValid_i  (wbRpValid_o),
    .wbLp_i     (wbLp),        .wbLpValid_i  (wbLpValid),
    .lwbLp_i    (lwbLpAddr_o), .lwbLpValid_i (lwbLpValid_o),
    .byp_o      (sByp_o)
  );

endmodule

`default_nettype wire

//--- design/bypassCmp.sv
// Bypass classification of one read-port address
// Purely combinational, youngest matching stage wins
`default_nettype none

module bypassCmp
(
  input  gprAddrPkg::gprAddr_t    portAddr_i,
  input  gprAddrPkg::gprAddr_t    exeRp_i,
  input  wire                     exeRpValid_i,
  input  gprAddrPkg::gprAddr_t    exeLp_i,
  input  wire                     exeLpValid_i,
  input  gprAddrPkg::gprAddr_t    wbRp_i,
  input  wire                     wbRpValid_i,
  input  gprAddrPkg::gprAddr_t    wbLp_i,
  input  wire                     wbLpValid_i,
  input  gprAddrPkg::gprAddr_t    lwbLp_i,
  input  wire                     lwbLpValid_i,
  output gprAddrPkg::bypSrc_t     byp_o
);

  logic exeLpHit;
  logic exeRpHit;
  logic wbHit;
  logic lwbHit;

  assign exeLpHit = exeLpValid_i && (exeLp_i == portAddr_i);
  assign exeRpHit = exeRpValid_i && (exeRp_i == portAddr_i);
  assign wbHit    = (wbRpValid_i && (wbRp_i == portAddr_i)) ||
                    (wbLpValid_i && (wbLp_i == portAddr_i));
  assign lwbHit   = lwbLpValid_i && (lwbLp_i == portAddr_i);

  // Load data in exe is not ready yet, so the reader waits
  always_comb
  begin
    if (exeLpHit)
      byp_o = gprAddrPkg::BYP_WAIT;
    else if (exeRpHit)
      byp_o = gprAddrPkg::BYP_EXE;
    else if (wbHit)
      byp_o = gprAddrPkg::BYP_WB;
    else if (lwbHit)
      byp_o = gprAddrPkg::BYP_LWB;
    else
      byp_o = gprAddrPkg::BYP_NONE;
  end

endmodule

`default_nettype wire

//--- design/targetPipe.sv
// Target address pipeline for the exe, wb and lwb stages
// All stages advance together on every edge with hold_i low
// Stage addresses are unknown after reset until a transfer fills them
`default_nettype none

module targetPipe
(
  input  wire                     CB,
  input  wire                     rstN_i,
  input  wire                     hold_i,
  input  wire                     issue_i,
  input  gprAddrPkg::gprAddr_t    issueRp_i,
  input  wire                     issueRpValid_i,
  input  gprAddrPkg::gprAddr_t    issueLp_i,
  input  wire                     issueLpValid_i,
  output gprAddrPkg::gprAddr_t    exeRp_o,
  output logic                    exeRpValid_o,
  output gprAddrPkg::gprAddr_t    exeLp_o,
  output logic                    exeLpValid_o,
  output gprAddrPkg::gprAddr_t    wbRp_o,
  output logic                    wbRpValid_o,
  output gprAddrPkg::gprAddr_t    wbLp_o,
  output logic                    wbLpValid_o,
  output gprAddrPkg::gprAddr_t    lwbLp_o,
  output logic                    lwbLpValid_o
);

  // *******************************************************************
  // Stage valids
  // *******************************************************************
  always_ff @(posedge CB or negedge rstN_i)
  begin
    if (!rstN_i)
    begin
      exeRpValid_o <= 1'b0;
      exeLpValid_o <= 1'b0;
      wbRpValid_o  <= 1'b0;
      wbLpValid_o  <= 1'b0;
      lwbLpValid_o <= 1'b0;
    end
    else if (!hold_i)
    begin
      // Bubble enters exe when nothing issues
      exeRpValid_o <= issue_i && issueRpValid_i;
      exeLpValid_o <= issue_i && issueLpValid_i;
      wbRpValid_o  <= exeRpValid_o;
      wbLpValid_o  <= exeLpValid_o;
      lwbLpValid_o <= wbLpValid_o;
    end
  end

  // *******************************************************************
  // Stage addresses
  // *******************************************************************
  always_ff @(posedge CB)
  begin
    if (!hold_i)
    begin
      exeRp_o <= issueRp_i;
      exeLp_o <= issueLp_i;
      wbRp_o  <= exeRp_o;
      wbLp_o  <= exeLp_o;
      lwbLp_o <= wbLp_o;
    end
  end

endmodule

`default_nettype wire

//--- design/gprAddrCtrl.sv
// Decode and issue control for the GPR read and target addresses
// Opcode fields must stay steady until dcdAccept_o pulses
// lmw/stmw issue one transfer per register from rsRt up to register 31
`default_nettype none

`include "gprAddr_config.svh"

module gprAddrCtrl
(
  input  wire                     CB,
  input  wire                     rstN_i,
  input  wire                     dcdValid_i,
  input  wire                     hold_i,
  input  gprAddrPkg::priOp_t      priOp_i,
  input  gprAddrPkg::extOp_t      extOp_i,
  input  gprAddrPkg::gprAddr_t    ra_i,
  input  gprAddrPkg::gprAddr_t    rb_i,
  input  gprAddrPkg::gprAddr_t    rsRt_i,
  output logic                    dcdAccept_o,
  output gprAddrPkg::gprAddr_t    aAddr_o,
  output gprAddrPkg::gprAddr_t    bAddr_o,
  output gprAddrPkg::gprAddr_t    sAddr_o,
  output logic                    issue_o,
  output gprAddrPkg::gprAddr_t    issueRp_o,
  output logic                    issueRpValid_o,
  output gprAddrPkg::gprAddr_t    issueLp_o,
  output logic                    issueLpValid_o
);

  gprAddrPkg::opKind_t    opKind;
  gprAddrPkg::ctrlState_t stateQ;
  gprAddrPkg::ctrlState_t stateD;
  gprAddrPkg::gprAddr_t   idxQ;
  gprAddrPkg::gprAddr_t   idxD;
  gprAddrPkg::gprAddr_t   curIdx;
  logic                   isMulti;
  logic                   lastXfer;
  logic                   issue;

  // *******************************************************************
  // Opcode decode
  // *******************************************************************
  always_comb
  begin
    opKind = gprAddrPkg::OP_NONE;
    case (priOp_i)
      `OP_ADDI: opKind = gprAddrPkg::OP_RESULT;
      `OP_LWZ:  opKind = gprAddrPkg::OP_LOAD;
      `OP_STW:  opKind = gprAddrPkg::OP_STORE;
      `OP_LMW:  opKind = gprAddrPkg::OP_LOADMULTI;
      `OP_STMW: opKind = gprAddrPkg::OP_STOREMULTI;
      `OP_EXT:
      begin
        case (extOp_i)
          `XO_ADD:  opKind = gprAddrPkg::OP_RESULT;
          `XO_LWZX: opKind = gprAddrPkg::OP_LOAD;
          `XO_STWX: opKind = gprAddrPkg::OP_STORE;
          default:  opKind = gprAddrPkg::OP_NONE;
        endcase
      end
      default: opKind = gprAddrPkg::OP_NONE;
    endcase
  end

  assign isMulti = (opKind == gprAddrPkg::OP_LOADMULTI) ||
                   (opKind == gprAddrPkg::OP_STOREMULTI);

  // *******************************************************************
  // Multiple-op sequencer
  // *******************************************************************
  // First transfer of a multiple op uses rsRt directly
  assign curIdx   = (stateQ == gprAddrPkg::MULTI) ? idxQ : rsRt_i;
  assign lastXfer = (curIdx == gprAddrPkg::gprAddr_t'(`LAST_GPR));
  assign issue    = dcdValid_i && !hold_i;

  always_comb
  begin
    stateD = stateQ;
    idxD   = idxQ;
    if (issue && isMulti)
    begin
      if (lastXfer)
      begin
        stateD = gprAddrPkg::IDLE;
      end
      else
      begin
        stateD = gprAddrPkg::MULTI;
        idxD   = curIdx + gprAddrPkg::gprAddr_t'(1);
      end
    end
  end

  always_ff @(posedge CB or negedge rstN_i)
  begin
    if (!rstN_i)
    begin
      stateQ <= gprAddrPkg::IDLE;
      idxQ   <= '0;
    end
    else
    begin
      stateQ <= stateD;
      idxQ   <= idxD;
    end
  end

  // Single ops finish in one transfer
  assign dcdAccept_o = issue && (!isMulti || lastXfer);
  assign issue_o     = issue;

  // *******************************************************************
  // Read ports and targets
  // *******************************************************************
  assign aAddr_o = ra_i;
  assign bAddr_o = rb_i;
  assign sAddr_o = (opKind == gprAddrPkg::OP_STOREMULTI) ? curIdx : rsRt_i;

  assign issueRp_o      = rsRt_i;
  assign issueRpValid_o = (opKind == gprAddrPkg::OP_RESULT);

  // lmw walks the load target along with the index
  assign issueLp_o      = (opKind == gprAddrPkg::OP_LOADMULTI) ? curIdx : rsRt_i;
  assign issueLpValid_o = (opKind == gprAddrPkg::OP_LOAD) ||
                          (opKind == gprAddrPkg::OP_LOADMULTI);

endmodule

`default_nettype wire

//--- design/gprAddrPkg.sv
// Types shared by the GPR address generator blocks
// Widths come from the config header
`default_nettype none

`include "gprAddr_config.svh"

package gprAddrPkg;

  typedef logic [`GPR_ADDR_W-1:0] gprAddr_t;
  typedef logic [`PRI_OP_W-1:0]   priOp_t;
  typedef logic [`EXT_OP_W-1:0]   extOp_t;

  // Decoded operation class
  typedef enum logic [2:0] {
    OP_RESULT,
    OP_LOAD,
    OP_STORE,
    OP_LOADMULTI,
    OP_STOREMULTI,
    OP_NONE
  } opKind_t;

  // Multiple-op sequencer
  typedef enum logic {
    IDLE,
    MULTI
  } ctrlState_t;

  // Bypass source for one read port, youngest stage wins
  typedef enum logic [2:0] {
    BYP_NONE,
    BYP_EXE,
    BYP_WB,
    BYP_LWB,
    BYP_WAIT
  } bypSrc_t;

endpackage

`default_nettype wire

//--- design/gprAddr_config.svh
// Widths and opcode encodings for the GPR address generator
// Opcode values follow the PowerPC primary and extended opcode fields
// Only the small opcode subset listed here is decoded, all others are ignored
`ifndef GPR_ADDR_CONFIG_SVH
`define GPR_ADDR_CONFIG_SVH

// Field widths
`define GPR_ADDR_W 5
`define PRI_OP_W   6
`define EXT_OP_W   10

// Highest register index, end of load/store multiple
`define LAST_GPR   31

// Primary opcodes
`define OP_ADDI    6'd14
`define OP_EXT     6'd31
`define OP_LWZ     6'd32
`define OP_STW     6'd36
`define OP_LMW     6'd46
`define OP_STMW    6'd47

// Extended opcodes under OP_EXT
`define XO_LWZX    10'd23
`define XO_STWX    10'd151
`define XO_ADD     10'd266

`endif
